// ==== files.f ====
hdl/csr_pkg.sv
hdl/csr_decode.sv
hdl/csr_regfile.sv
hdl/csr_result.sv
hdl/csr_unit.sv
bench/csr_unit_properties.sv
bench/csr_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module csr_unit_tb -o csr_unit_sim

./obj_dir/csr_unit_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== bench/csr_unit_tb.sv ====
`timescale 1ns/100ps

module csr_unit_tb;

    // what the outputs must show one cycle after the inputs were taken
    typedef struct packed {
        logic        wb_we;
        logic [4:0]  wb_addr;
        logic [31:0] wb_data;
        logic        data_known;
        logic        redir_valid;
        logic [31:0] target;
        logic        target_known;
    } expect_t;

    logic               clk;
    logic               reset;
    logic               inst_valid;
    logic [31:0]        inst;
    logic [31:0]        rj_value;
    logic [31:0]        rd_value;
    csr_pkg::trap_t     trap;
    csr_pkg::wb_t       wb;
    csr_pkg::redirect_t redirect;

    logic [31:0] lfsr;
    expect_t     exp_q [$];
    expect_t     pending;
    logic        pending_valid;

    // reference copy of the csr fields
    logic [1:0]  m_plv, m_pplv, m_datf, m_datm, m_is;
    logic        m_ie, m_da, m_pg, m_pie;
    logic [5:0]  m_ecode;
    logic [8:0]  m_esub;
    logic [31:0] m_era, m_eentry;
    logic [31:0] m_save [4];
    logic        m_known [9];  // false while the dut value is still undefined

    csr_unit u_csr_unit (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .rj_value   (rj_value),
        .rd_value   (rd_value),
        .trap       (trap),
        .wb         (wb),
        .redirect   (redirect)
    );

    bind csr_unit csr_unit_properties u_properties (
        .clk      (clk),
        .reset    (reset),
        .trap     (trap),
        .wb       (wb),
        .redirect (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int csr_index(input logic [13:0] num);
        case (num)
            csr_pkg::CSR_CRMD:   return 0;
            csr_pkg::CSR_PRMD:   return 1;
            csr_pkg::CSR_ESTAT:  return 2;
            csr_pkg::CSR_ERA:    return 3;
            csr_pkg::CSR_EENTRY: return 4;
            csr_pkg::CSR_SAVE0:  return 5;
            csr_pkg::CSR_SAVE1:  return 6;
            csr_pkg::CSR_SAVE2:  return 7;
            csr_pkg::CSR_SAVE3:  return 8;
            default:             return -1;
        endcase
    endfunction

    function automatic logic [13:0] csr_num_at(input int i);
        case (i)
            0: return csr_pkg::CSR_CRMD;
            1: return csr_pkg::CSR_PRMD;
            2: return csr_pkg::CSR_ESTAT;
            3: return csr_pkg::CSR_ERA;
            4: return csr_pkg::CSR_EENTRY;
            5: return csr_pkg::CSR_SAVE0;
            6: return csr_pkg::CSR_SAVE1;
            7: return csr_pkg::CSR_SAVE2;
            8: return csr_pkg::CSR_SAVE3;
            default: return 14'h100 + 14'(i);  // not implemented
        endcase
    endfunction

    function automatic logic [31:0] model_read(input logic [13:0] num);
        int idx;
        idx = csr_index(num);
        case (idx)
            0: return {23'b0, m_datm, m_datf, m_pg, m_da, m_ie, m_plv};
            1: return {29'b0, m_pie, m_pplv};
            2: return {1'b0, m_esub, m_ecode, 14'b0, m_is};
            3: return m_era;
            4: return m_eentry;
            5, 6, 7, 8: return m_save[idx - 5];
            default: return 32'b0;
        endcase
    endfunction

    function automatic logic model_known(input logic [13:0] num);
        int idx;
        idx = csr_index(num);
        return idx < 0 ? 1'b1 : m_known[idx];
    endfunction

    // masked merge, then keep only the writable fields
    function automatic void model_write(input logic [13:0] num, input logic [31:0] mask,
                                        input logic [31:0] value, input logic full);
        logic [31:0] v;
        int          idx;
        idx = csr_index(num);
        v   = (value & mask) | (model_read(num) & ~mask);
        case (idx)
            0: begin
                m_plv  = v[1:0];
                m_ie   = v[2];
                m_da   = v[3];
                m_pg   = v[4];
                m_datf = v[6:5];
                m_datm = v[8:7];
            end
            1: begin
                m_pplv = v[1:0];
                m_pie  = v[2];
            end
            2: m_is = v[1:0];  // ecode and esubcode are read only
            3: m_era = v;
            4: m_eentry = {v[31:6], 6'b0};
            5, 6, 7, 8: m_save[idx - 5] = v;
            default: ;
        endcase
        if (full && idx >= 0 && idx != 2) begin
            m_known[idx] = 1'b1;
        end
    endfunction

    // reference model for one input cycle
    function automatic expect_t predict(input logic valid, input logic [31:0] in,
                                        input logic [31:0] rj_v, input logic [31:0] rd_v,
                                        input csr_pkg::trap_t tr);
        expect_t     e;
        logic        is_csr;
        logic [13:0] num;
        logic [4:0]  rj;
        is_csr         = in[31:24] == csr_pkg::CSR_OPCODE;
        num            = in[23:10];
        rj             = in[9:5];
        e.wb_we        = valid && is_csr && !tr.ex && !tr.ertn;
        e.wb_addr      = in[4:0];
        e.wb_data      = model_read(num);
        e.data_known   = model_known(num);
        e.redir_valid  = tr.ex || tr.ertn;
        e.target       = tr.ex ? m_eentry : m_era;
        e.target_known = tr.ex ? m_known[4] : m_known[3];
        if (tr.ex) begin
            m_pplv     = m_plv;
            m_pie      = m_ie;
            m_plv      = 2'b0;
            m_ie       = 1'b0;
            m_ecode    = tr.ecode;
            m_esub     = tr.esubcode;
            m_era      = tr.pc;
            m_known[1] = 1'b1;
            m_known[2] = 1'b1;
            m_known[3] = 1'b1;
        end else if (tr.ertn) begin
            m_plv = m_pplv;
            m_ie  = m_pie;
        end else if (e.wb_we && rj != 5'd0) begin
            model_write(num, rj == 5'd1 ? 32'hffff_ffff : rj_v, rd_v, rj == 5'd1);
        end
        return e;
    endfunction

    function automatic logic [31:0] csr_inst(input logic [4:0] rj, input logic [13:0] num,
                                             input logic [4:0] rd);
        return {csr_pkg::CSR_OPCODE, num, rj, rd};
    endfunction

    task automatic check_equal(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("Finished with errors");
            $fatal(1, "output mismatch");
        end
    endtask

    // drive on the falling edge and queue the prediction
    task automatic step(input logic valid, input logic [31:0] in, input logic [31:0] rj_v,
                        input logic [31:0] rd_v, input csr_pkg::trap_t tr);
        @(negedge clk);
        inst_valid = valid;
        inst       = in;
        rj_value   = rj_v;
        rd_value   = rd_v;
        trap       = tr;
        exp_q.push_back(predict(valid, in, rj_v, rd_v, tr));
    endtask

    // rj 0 reads, 1 writes, anything else exchanges
    task automatic csr_issue(input logic [4:0] rj, input logic [13:0] num);
        step(1'b1, csr_inst(rj, num, 5'(rand_bits(5))), rand_bits(32), rand_bits(32), '0);
    endtask

    function automatic logic [4:0] xchg_rj();
        logic [4:0] rj;
        rj = 5'(rand_bits(5));
        return rj < 5'd2 ? rj + 5'd2 : rj;
    endfunction

    task automatic trap_step(input logic ex, input logic ertn);
        csr_pkg::trap_t tr;
        tr.ex       = ex;
        tr.ertn     = ertn;
        tr.ecode    = 6'(rand_bits(6));
        tr.esubcode = 9'(rand_bits(9));
        tr.pc       = rand_bits(32);
        // csrwr next to the trap is dropped
        step(1'b1, csr_inst(5'd1, csr_pkg::CSR_SAVE0 + 14'(rand_bits(2)), 5'(rand_bits(5))),
             rand_bits(32), rand_bits(32), tr);
    endtask

    task automatic random_step();
        csr_pkg::trap_t tr;
        logic [31:0]    in;
        logic [4:0]     rj;
        logic [3:0]     kind;
        kind        = 4'(rand_bits(4));
        tr.ex       = kind == 4'd0 || kind == 4'd2;
        tr.ertn     = kind == 4'd1 || kind == 4'd2;
        tr.ecode    = 6'(rand_bits(6));
        tr.esubcode = 9'(rand_bits(9));
        tr.pc       = rand_bits(32);
        rj          = 5'(rand_bits(5));
        if (rj > 5'd20) begin
            rj = rj & 5'd1;  // more plain reads and writes
        end
        in = csr_inst(rj, csr_num_at(int'(rand_bits(4))), 5'(rand_bits(5)));
        if (kind >= 4'd12) begin
            in[31:24] = 8'(rand_bits(8));  // mostly another major opcode
        end
        step(rand_bits(3) != 32'd0, in, rand_bits(32), rand_bits(32), tr);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_q.size() != 0 || pending_valid) && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0 || pending_valid) begin
            $display("timeout while waiting for the last expected results to be compared");
            $display("Finished with errors");
            $fatal(1, "drain timeout");
        end
    endtask

    // outputs registered at the previous edge against their prediction
    always @(posedge clk) begin
        if (pending_valid) begin
            check_equal("wb.we", 32'(wb.we), 32'(pending.wb_we));
            if (pending.wb_we) begin
                check_equal("wb.addr", 32'(wb.addr), 32'(pending.wb_addr));
                if (pending.data_known) begin
                    check_equal("wb.data", wb.data, pending.wb_data);
                end
            end
            check_equal("redirect.valid", 32'(redirect.valid), 32'(pending.redir_valid));
            if (pending.redir_valid && pending.target_known) begin
                check_equal("redirect.target", redirect.target, pending.target);
            end
        end
        pending_valid = exp_q.size() != 0;
        if (pending_valid) begin
            pending = exp_q.pop_front();
        end
    end

    initial begin
        lfsr          = 32'h7fd22f54;
        pending_valid = 1'b0;
        reset         = 1'b1;
        inst_valid    = 1'b0;
        inst          = '0;
        rj_value      = '0;
        rd_value      = '0;
        trap          = '0;
        // crmd after reset is direct address mode only
        m_plv  = 2'b0;
        m_ie   = 1'b0;
        m_da   = 1'b1;
        m_pg   = 1'b0;
        m_datf = 2'b0;
        m_datm = 2'b0;
        m_is   = 2'b0;
        for (int i = 0; i < 9; i++) begin
            m_known[i] = i == 0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        csr_issue(5'd0, csr_pkg::CSR_CRMD);
        for (int i = 0; i < 4; i++) begin
            csr_issue(5'd0, 14'h040 + 14'(rand_bits(8)));
        end
        // give the undefined registers a value and let the exception fill in ecode
        for (int i = 1; i < 9; i++) begin
            csr_issue(5'd1, csr_num_at(i));
        end
        trap_step(1'b1, 1'b0);

        for (int i = 0; i < 9; i++) begin
            csr_issue(5'd1, csr_num_at(i));
            csr_issue(5'd0, csr_num_at(i));
        end
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 9; i++) begin
                csr_issue(xchg_rj(), csr_num_at(i));
                csr_issue(5'd0, csr_num_at(i));
            end
        end

        for (int r = 0; r < 3; r++) begin
            csr_issue(5'd1, csr_pkg::CSR_CRMD);
            csr_issue(5'd1, csr_pkg::CSR_EENTRY);
            trap_step(1'b1, 1'b0);
            for (int i = 0; i < 9; i++) begin
                csr_issue(5'd0, csr_num_at(i));
            end
        end
        for (int r = 0; r < 3; r++) begin
            csr_issue(5'd1, csr_pkg::CSR_PRMD);
            csr_issue(5'd1, csr_pkg::CSR_ERA);
            trap_step(1'b0, 1'b1);
            csr_issue(5'd0, csr_pkg::CSR_CRMD);
        end
        trap_step(1'b1, 1'b1);  // ex wins
        csr_issue(5'd0, csr_pkg::CSR_CRMD);
        csr_issue(5'd0, csr_pkg::CSR_ESTAT);

        repeat (400) random_step();
        step(1'b0, 32'b0, 32'b0, 32'b0, '0);
        wait_drain();

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== bench/csr_unit_properties.sv ====
`timescale 1ns/100ps

module csr_unit_properties (
    input logic               clk,
    input logic               reset,
    input csr_pkg::trap_t     trap,
    input csr_pkg::wb_t       wb,
    input csr_pkg::redirect_t redirect
);

    logic trap_any;

    assign trap_any = trap.ex || trap.ertn;

    // both strobes leave reset low
    reset_clears_strobes: assert property (@(posedge clk) reset |=> !wb.we && !redirect.valid)
        else $error("wb.we or redirect.valid high in the cycle after reset");

    // a lone trap gives a single redirect cycle
    redirect_single_cycle: assert property (@(posedge clk) disable iff (reset)
        redirect.valid && !trap_any |=> !redirect.valid)
        else $error("redirect.valid held for two cycles after a single trap");

    trap_gives_redirect: assert property (@(posedge clk) disable iff (reset)
        trap_any |=> redirect.valid)
        else $error("trap without a redirect in the next cycle");

    trap_drops_wb: assert property (@(posedge clk) disable iff (reset)
        trap_any |=> !wb.we)  // instruction next to a trap is discarded
        else $error("write-back in the cycle after a trap");

endmodule

// ==== hdl/csr_unit.sv ====
`timescale 1ns/100ps

module csr_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               inst_valid,
    input  logic [31:0]        inst,
    input  logic [31:0]        rj_value,
    input  logic [31:0]        rd_value,
    input  csr_pkg::trap_t     trap,
    output csr_pkg::wb_t       wb,
    output csr_pkg::redirect_t redirect
);

    csr_pkg::csr_req_t req;
    logic [4:0]        rd_addr;
    logic [31:0]       read_value;
    logic [31:0]       ex_entry;
    logic [31:0]       ertn_entry;

    csr_decode u_decode (
        .inst_valid (inst_valid),
        .inst       (inst),
        .rj_value   (rj_value),
        .rd_value   (rd_value),
        .req        (req),
        .rd_addr    (rd_addr)
    );

    csr_regfile u_regfile (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .trap       (trap),
        .read_value (read_value),
        .ex_entry   (ex_entry),
        .ertn_entry (ertn_entry)
    );

    csr_result u_result (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .op         (req.op),
        .rd_addr    (rd_addr),
        .read_value (read_value),
        .trap       (trap),
        .ex_entry   (ex_entry),
        .ertn_entry (ertn_entry),
        .wb         (wb),
        .redirect   (redirect)
    );

endmodule

// ==== hdl/csr_result.sv ====
`timescale 1ns/100ps

module csr_result (
    input  logic               clk,
    input  logic               reset,
    input  logic               inst_valid,
    input  csr_pkg::csr_op_t   op,
    input  logic [4:0]         rd_addr,
    input  logic [31:0]        read_value,
    input  csr_pkg::trap_t     trap,
    input  logic [31:0]        ex_entry,
    input  logic [31:0]        ertn_entry,
    output csr_pkg::wb_t       wb,
    output csr_pkg::redirect_t redirect
);

    logic        wb_we_q;
    logic [4:0]  wb_addr_q;
    logic [31:0] wb_data_q;
    logic        redir_valid_q;
    logic [31:0] redir_target_q;
    logic        trap_any;

    assign trap_any = trap.ex || trap.ertn;

    // one-cycle strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_we_q       <= 1'b0;
            redir_valid_q <= 1'b0;
        end else begin
            wb_we_q       <= inst_valid && op != csr_pkg::op_none && !trap_any;
            redir_valid_q <= trap_any;
        end
    end

    // payload, old csr value and entry address before the edge
    always_ff @(posedge clk) begin
        wb_addr_q      <= rd_addr;
        wb_data_q      <= read_value;
        redir_target_q <= trap.ex ? ex_entry : ertn_entry;  // ex wins over ertn
    end

    assign wb.we           = wb_we_q;
    assign wb.addr         = wb_addr_q;
    assign wb.data         = wb_data_q;
    assign redirect.valid  = redir_valid_q;
    assign redirect.target = redir_target_q;

endmodule

// ==== hdl/csr_regfile.sv ====
`timescale 1ns/100ps

module csr_regfile (
    input  logic              clk,
    input  logic              reset,
    input  csr_pkg::csr_req_t req,
    input  csr_pkg::trap_t    trap,
    output logic [31:0]       read_value,
    output logic [31:0]       ex_entry,
    output logic [31:0]       ertn_entry
);

    // crmd fields
    logic [1:0]  crmd_plv;
    logic        crmd_ie;
    logic        crmd_da;
    logic        crmd_pg;
    logic [1:0]  crmd_datf;
    logic [1:0]  crmd_datm;
    // prmd fields
    logic [1:0]  prmd_pplv;
    logic        prmd_pie;
    // estat fields
    logic [1:0]  estat_is;
    logic [5:0]  estat_ecode;
    logic [8:0]  estat_esubcode;
    logic [31:0] era;
    logic [25:0] eentry_va;
    logic [31:0] save_q [4];

    logic [31:0] crmd_data, prmd_data, estat_data, eentry_data;
    logic [31:0] crmd_wr, prmd_wr, estat_wr, era_wr, eentry_wr;
    logic        wr_en;

    // a trap in the same cycle discards the write
    assign wr_en = req.we && !trap.ex && !trap.ertn;

    function automatic logic [31:0] merge(input logic [31:0] old_v,
                                          input logic [31:0] mask,
                                          input logic [31:0] value);
        return (mask & value) | (~mask & old_v);
    endfunction

    assign crmd_data   = {23'b0, crmd_datm, crmd_datf, crmd_pg, crmd_da, crmd_ie, crmd_plv};
    assign prmd_data   = {29'b0, prmd_pie, prmd_pplv};
    assign estat_data  = {1'b0, estat_esubcode, estat_ecode, 3'b0, 11'b0, estat_is};
    assign eentry_data = {eentry_va, 6'b0};

    assign crmd_wr   = merge(crmd_data, req.wmask, req.wvalue);
    assign prmd_wr   = merge(prmd_data, req.wmask, req.wvalue);
    assign estat_wr  = merge(estat_data, req.wmask, req.wvalue);
    assign era_wr    = merge(era, req.wmask, req.wvalue);
    assign eentry_wr = merge(eentry_data, req.wmask, req.wvalue);

    // privilege and interrupt enable, traps first
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= csr_pkg::CRMD_RESET[csr_pkg::CRMD_PLV +: 2];
            crmd_ie  <= csr_pkg::CRMD_RESET[csr_pkg::CRMD_IE];
        end else if (trap.ex) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (trap.ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr_en && req.num == csr_pkg::CSR_CRMD) begin
            crmd_plv <= crmd_wr[csr_pkg::CRMD_PLV +: 2];
            crmd_ie  <= crmd_wr[csr_pkg::CRMD_IE];
        end
    end

    // translation mode bits change only by csr write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_da   <= csr_pkg::CRMD_RESET[csr_pkg::CRMD_DA];
            crmd_pg   <= csr_pkg::CRMD_RESET[csr_pkg::CRMD_PG];
            crmd_datf <= csr_pkg::CRMD_RESET[csr_pkg::CRMD_DATF +: 2];
            crmd_datm <= csr_pkg::CRMD_RESET[csr_pkg::CRMD_DATM +: 2];
        end else if (wr_en && req.num == csr_pkg::CSR_CRMD) begin
            crmd_da   <= crmd_wr[csr_pkg::CRMD_DA];
            crmd_pg   <= crmd_wr[csr_pkg::CRMD_PG];
            crmd_datf <= crmd_wr[csr_pkg::CRMD_DATF +: 2];
            crmd_datm <= crmd_wr[csr_pkg::CRMD_DATM +: 2];
        end
    end

    always_ff @(posedge clk) begin
        if (trap.ex) begin  // save mode of the interrupted code
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (wr_en && req.num == csr_pkg::CSR_PRMD) begin
            prmd_pplv <= prmd_wr[csr_pkg::PRMD_PPLV +: 2];
            prmd_pie  <= prmd_wr[csr_pkg::PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            estat_is <= 2'b0;
        end else if (wr_en && req.num == csr_pkg::CSR_ESTAT) begin
            estat_is <= estat_wr[csr_pkg::ESTAT_IS +: 2];  // software bits only
        end
    end

    // cause and return address captured on exception
    always_ff @(posedge clk) begin
        if (trap.ex) begin
            estat_ecode    <= trap.ecode;
            estat_esubcode <= trap.esubcode;
        end
    end

    always_ff @(posedge clk) begin
        if (trap.ex) begin
            era <= trap.pc;
        end else if (wr_en && req.num == csr_pkg::CSR_ERA) begin
            era <= era_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && req.num == csr_pkg::CSR_EENTRY) begin
            eentry_va <= eentry_wr[csr_pkg::EENTRY_VA +: 26];
        end
        for (int i = 0; i < 4; i++) begin
            if (wr_en && req.num == csr_pkg::CSR_SAVE0 + 14'(i)) begin
                save_q[i] <= merge(save_q[i], req.wmask, req.wvalue);
            end
        end
    end

    // unknown numbers read zero
    always_comb begin
        case (req.num)
            csr_pkg::CSR_CRMD:   read_value = crmd_data;
            csr_pkg::CSR_PRMD:   read_value = prmd_data;
            csr_pkg::CSR_ESTAT:  read_value = estat_data;
            csr_pkg::CSR_ERA:    read_value = era;
            csr_pkg::CSR_EENTRY: read_value = eentry_data;
            csr_pkg::CSR_SAVE0:  read_value = save_q[0];
            csr_pkg::CSR_SAVE1:  read_value = save_q[1];
            csr_pkg::CSR_SAVE2:  read_value = save_q[2];
            csr_pkg::CSR_SAVE3:  read_value = save_q[3];
            default:             read_value = '0;
        endcase
    end

    assign ex_entry   = eentry_data;
    assign ertn_entry = era;

endmodule

// ==== hdl/csr_decode.sv ====
`timescale 1ns/100ps

module csr_decode (
    input  logic              inst_valid,
    input  logic [31:0]       inst,
    input  logic [31:0]       rj_value,
    input  logic [31:0]       rd_value,
    output csr_pkg::csr_req_t req,
    output logic [4:0]        rd_addr
);

    logic             is_csr;
    logic [4:0]       rj;
    csr_pkg::csr_op_t op;
    logic [31:0]      wmask;

    assign is_csr  = inst[31:24] == csr_pkg::CSR_OPCODE;
    assign rj      = inst[9:5];
    assign rd_addr = inst[4:0];

    // rj selects between csrrd, csrwr and csrxchg
    always_comb begin
        op    = csr_pkg::op_none;
        wmask = '0;
        if (is_csr) begin
            case (rj)
                csr_pkg::RJ_CSRRD: begin
                    op = csr_pkg::op_rd;
                end
                csr_pkg::RJ_CSRWR: begin
                    op    = csr_pkg::op_wr;
                    wmask = '1;  // full overwrite
                end
                default: begin
                    op    = csr_pkg::op_xchg;
                    wmask = rj_value;  // rj register holds the mask
                end
            endcase
        end
    end

    assign req.op     = op;
    assign req.num    = inst[23:10];
    assign req.we     = inst_valid && (op == csr_pkg::op_wr || op == csr_pkg::op_xchg);
    assign req.wmask  = wmask;
    assign req.wvalue = rd_value;

endmodule

// ==== hdl/csr_pkg.sv ====
package csr_pkg;

    // csr instruction operation, chosen from the rj field
    typedef enum logic [1:0] {
        op_none,
        op_rd,
        op_wr,
        op_xchg
    } csr_op_t;

    // major opcode in inst[31:24]
    localparam logic [7:0] CSR_OPCODE = 8'h04;

    // rj values with a fixed meaning
    localparam logic [4:0] RJ_CSRRD = 5'd0;
    localparam logic [4:0] RJ_CSRWR = 5'd1;

    // implemented csr numbers
    localparam logic [13:0] CSR_CRMD   = 14'h000;
    localparam logic [13:0] CSR_PRMD   = 14'h001;
    localparam logic [13:0] CSR_ESTAT  = 14'h005;
    localparam logic [13:0] CSR_ERA    = 14'h006;
    localparam logic [13:0] CSR_EENTRY = 14'h00c;
    localparam logic [13:0] CSR_SAVE0  = 14'h030;
    localparam logic [13:0] CSR_SAVE1  = 14'h031;
    localparam logic [13:0] CSR_SAVE2  = 14'h032;
    localparam logic [13:0] CSR_SAVE3  = 14'h033;

    // field lsb positions
    localparam int CRMD_PLV       = 0;  // 2 bits
    localparam int CRMD_IE        = 2;
    localparam int CRMD_DA        = 3;
    localparam int CRMD_PG        = 4;
    localparam int CRMD_DATF      = 5;  // 2 bits
    localparam int CRMD_DATM      = 7;  // 2 bits
    localparam int PRMD_PPLV      = 0;  // 2 bits
    localparam int PRMD_PIE       = 2;
    localparam int ESTAT_IS       = 0;  // only the two software bits are stored
    localparam int ESTAT_ECODE    = 16; // 6 bits
    localparam int ESTAT_ESUBCODE = 22; // 9 bits
    localparam int EENTRY_VA      = 6;  // 26 bits, low bits read zero

    // direct address mode after reset
    localparam logic [31:0] CRMD_RESET = 32'h0000_0008;

    // request from decode into the register file
    typedef struct packed {
        csr_op_t     op;
        logic [13:0] num;
        logic        we;
        logic [31:0] wmask;
        logic [31:0] wvalue;
    } csr_req_t;

    // exception and exception return from write-back
    typedef struct packed {
        logic        ex;
        logic        ertn;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] pc;
    } trap_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  addr;
        logic [31:0] data;
    } wb_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

endpackage
